/* src/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and byte address width.
`define CPU_XLEN 32

// register address width, giving 32 general registers.
`define CPU_RADDR_W 5

// first fetch address after reset.
`define CPU_RESET_PC 32'h0000_0000

`endif

/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// major opcodes, anything else runs as a no-op.
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	// field positions inside the instruction word.
	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int RD_MSB    = 15;
	localparam int RD_LSB    = 11;
	localparam int FUNCT_MSB = 5;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_MSB   = 15;
	localparam int IMM_LSB   = 0;

endpackage

`default_nettype wire

/* src/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	typedef enum logic {
		WB_ALU = 1'b0, // result of the execute stage.
		WB_MEM = 1'b1  // load data from the bus.
	} wb_sel_e;

	typedef enum logic [1:0] {
		DST_NONE = 2'd0,
		DST_RT   = 2'd1,
		DST_RD   = 2'd2
	} dst_sel_e;

endpackage

`default_nettype wire

/* src/pipe_walls.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module pipe_walls (
	input  wire                       clock,
	input  wire                       arst_n,
	input  wire                       do_hazard,
	input  wire                       do_flush,
	input  wire  [`CPU_XLEN-1:0]      if_instr,
	input  wire  [`CPU_XLEN-1:0]      if_pc,
	output logic [`CPU_XLEN-1:0]      id_instr,
	output logic [`CPU_XLEN-1:0]      id_pc,
	input  wire  [`CPU_XLEN-1:0]      id_ra_data,
	input  wire  [`CPU_XLEN-1:0]      id_rt_data,
	input  wire  [`CPU_XLEN-1:0]      id_imm,
	input  wire  [`CPU_RADDR_W-1:0]   id_rs,
	input  wire  [`CPU_RADDR_W-1:0]   id_rt,
	input  wire  [`CPU_RADDR_W-1:0]   id_dst,
	input  pipe_pkg::alu_op_e         id_alu_op,
	input  wire                       id_alu_imm,
	input  wire                       id_mem_read,
	input  wire                       id_mem_write,
	input  wire                       id_reg_write,
	input  pipe_pkg::wb_sel_e         id_wb_sel,
	output logic [`CPU_XLEN-1:0]      ex_ra_data,
	output logic [`CPU_XLEN-1:0]      ex_rt_data,
	output logic [`CPU_XLEN-1:0]      ex_imm,
	output logic [`CPU_RADDR_W-1:0]   ex_rs,
	output logic [`CPU_RADDR_W-1:0]   ex_rt,
	output logic [`CPU_RADDR_W-1:0]   ex_dst,
	output pipe_pkg::alu_op_e         ex_alu_op,
	output logic                      ex_alu_imm,
	output logic                      ex_mem_read,
	output logic                      ex_mem_write,
	output logic                      ex_reg_write,
	output pipe_pkg::wb_sel_e         ex_wb_sel,
	input  wire  [`CPU_XLEN-1:0]      ex_result,
	input  wire  [`CPU_XLEN-1:0]      ex_store_data,
	output logic [`CPU_XLEN-1:0]      mem_result,
	output logic [`CPU_XLEN-1:0]      mem_store_data,
	output logic [`CPU_RADDR_W-1:0]   mem_dst,
	output logic                      mem_mem_read,
	output logic                      mem_mem_write,
	output logic                      mem_reg_write,
	output pipe_pkg::wb_sel_e         mem_wb_sel,
	input  wire  [`CPU_XLEN-1:0]      wb_data,
	output logic [`CPU_RADDR_W-1:0]   wb_dst,
	output logic                      wb_reg_write,
	output logic [`CPU_XLEN-1:0]      wb_value
);

	// ******************************************************************
	// controls. A zero instruction and cleared enables form a no-op.
	// ******************************************************************
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			id_instr      <= '0;
			ex_dst        <= '0;
			ex_mem_read   <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_reg_write  <= 1'b0;
			mem_mem_read  <= 1'b0;
			mem_mem_write <= 1'b0;
			mem_reg_write <= 1'b0;
			wb_reg_write  <= 1'b0;
		end else begin
			if (do_flush)
				id_instr <= '0; // drop the fetch behind a taken branch.
			else if (!do_hazard)
				id_instr <= if_instr;

			// a stall turns the ID/EX slot into a bubble.
			ex_dst        <= do_hazard ? '0 : id_dst;
			ex_mem_read   <= id_mem_read & ~do_hazard;
			ex_mem_write  <= id_mem_write & ~do_hazard;
			ex_reg_write  <= id_reg_write & ~do_hazard;

			mem_mem_read  <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
			mem_reg_write <= ex_reg_write;
			wb_reg_write  <= mem_reg_write;
		end
	end

	// ******************************************************************
	// payload, qualified by the controls above.
	// ******************************************************************
	always_ff @(posedge clock) begin
		if (!do_hazard)
			id_pc <= if_pc;

		ex_ra_data     <= id_ra_data;
		ex_rt_data     <= id_rt_data;
		ex_imm         <= id_imm;
		ex_rs          <= id_rs;
		ex_rt          <= id_rt;
		ex_alu_op      <= id_alu_op;
		ex_alu_imm     <= id_alu_imm;
		ex_wb_sel      <= id_wb_sel;

		mem_result     <= ex_result;
		mem_store_data <= ex_store_data;
		mem_dst        <= ex_dst;
		mem_wb_sel     <= ex_wb_sel;

		wb_dst         <= mem_dst;
		wb_value       <= wb_data;
	end

endmodule

`default_nettype wire

/* src/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module decode_unit (
	input  wire                       clock,
	input  wire                       arst_n,
	input  wire  [`CPU_XLEN-1:0]      id_instr,
	input  wire  [`CPU_XLEN-1:0]      id_pc,
	input  wire  [`CPU_RADDR_W-1:0]   ex_dst,
	input  wire                       ex_mem_read,
	input  wire                       ex_reg_write,
	input  wire  [`CPU_RADDR_W-1:0]   mem_dst,
	input  wire                       mem_reg_write,
	input  wire  [`CPU_XLEN-1:0]      mem_result,
	input  wire  [`CPU_RADDR_W-1:0]   wb_dst,
	input  wire                       wb_reg_write,
	input  wire  [`CPU_XLEN-1:0]      wb_value,
	input  wire                       fetch_grant,
	output logic [`CPU_XLEN-1:0]      id_ra_data,
	output logic [`CPU_XLEN-1:0]      id_rt_data,
	output logic [`CPU_XLEN-1:0]      id_imm,
	output logic [`CPU_RADDR_W-1:0]   id_rs,
	output logic [`CPU_RADDR_W-1:0]   id_rt,
	output logic [`CPU_RADDR_W-1:0]   id_dst,
	output pipe_pkg::alu_op_e         id_alu_op,
	output logic                      id_alu_imm,
	output logic                      id_mem_read,
	output logic                      id_mem_write,
	output logic                      id_reg_write,
	output pipe_pkg::wb_sel_e         id_wb_sel,
	output logic                      branch_taken,
	output logic [`CPU_XLEN-1:0]      branch_target,
	output logic                      do_hazard,
	output logic                      do_flush
);

	logic [`CPU_XLEN-1:0]    regs [0:(1 << `CPU_RADDR_W)-1];
	isa_pkg::opcode_e        opcode;
	isa_pkg::funct_e         funct;
	pipe_pkg::dst_sel_e      dst_sel;
	logic [`CPU_RADDR_W-1:0] rd;
	logic [`CPU_XLEN-1:0]    cmp_a, cmp_b;
	logic                    is_beq, uses_rt, mem_is_load, load_use, branch_dep;

	// reads see a write from the MEM/WB wall in the same cycle.
	function automatic logic [`CPU_XLEN-1:0] rf_read(input logic [`CPU_RADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb_reg_write && wb_dst == addr)
			return wb_value;
		return regs[addr];
	endfunction

	always_ff @(posedge clock) begin
		if (wb_reg_write && wb_dst != '0)
			regs[wb_dst] <= wb_value;
	end

	assign id_rs  = id_instr[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
	assign id_rt  = id_instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
	assign rd     = id_instr[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
	assign id_imm = {{(`CPU_XLEN-16){id_instr[isa_pkg::IMM_MSB]}},
		id_instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB]};

	// ******************************************************************
	// controller
	// ******************************************************************
	always_comb begin
		opcode       = isa_pkg::opcode_e'(id_instr[isa_pkg::OP_MSB:isa_pkg::OP_LSB]);
		funct        = isa_pkg::funct_e'(id_instr[isa_pkg::FUNCT_MSB:isa_pkg::FUNCT_LSB]);
		dst_sel      = pipe_pkg::DST_NONE;
		id_alu_op    = pipe_pkg::ALU_ADD;
		id_alu_imm   = 1'b0;
		id_mem_read  = 1'b0;
		id_mem_write = 1'b0;
		id_wb_sel    = pipe_pkg::WB_ALU;
		is_beq       = 1'b0;
		uses_rt      = 1'b0;
		case (opcode)
			isa_pkg::OP_RTYPE: begin
				uses_rt = 1'b1;
				dst_sel = pipe_pkg::DST_RD;
				case (funct)
					isa_pkg::FN_ADD: id_alu_op = pipe_pkg::ALU_ADD;
					isa_pkg::FN_SUB: id_alu_op = pipe_pkg::ALU_SUB;
					isa_pkg::FN_AND: id_alu_op = pipe_pkg::ALU_AND;
					isa_pkg::FN_OR:  id_alu_op = pipe_pkg::ALU_OR;
					isa_pkg::FN_SLT: id_alu_op = pipe_pkg::ALU_SLT;
					default:         dst_sel = pipe_pkg::DST_NONE; // unknown funct.
				endcase
			end
			isa_pkg::OP_ADDI: begin
				dst_sel    = pipe_pkg::DST_RT;
				id_alu_imm = 1'b1;
			end
			isa_pkg::OP_LW: begin
				dst_sel     = pipe_pkg::DST_RT;
				id_alu_imm  = 1'b1;
				id_mem_read = 1'b1;
				id_wb_sel   = pipe_pkg::WB_MEM;
			end
			isa_pkg::OP_SW: begin
				uses_rt      = 1'b1;
				id_alu_imm   = 1'b1;
				id_mem_write = 1'b1;
			end
			isa_pkg::OP_BEQ: begin
				uses_rt = 1'b1;
				is_beq  = 1'b1;
			end
			default: ;
		endcase

		case (dst_sel)
			pipe_pkg::DST_RD: id_dst = rd;
			pipe_pkg::DST_RT: id_dst = id_rt;
			default:          id_dst = '0;
		endcase
		id_reg_write = (dst_sel != pipe_pkg::DST_NONE);
	end

	// ******************************************************************
	// operands, branch and hazards
	// ******************************************************************
	always_comb begin
		id_ra_data = rf_read(id_rs);
		id_rt_data = rf_read(id_rt);
		cmp_a      = id_ra_data; // MEM/WB forwarding comes with the write-first read.
		cmp_b      = id_rt_data;
		if (mem_reg_write && mem_dst != '0 && mem_dst == id_rs)
			cmp_a = mem_result;
		if (mem_reg_write && mem_dst != '0 && mem_dst == id_rt)
			cmp_b = mem_result;
	end

	// a load result is not in the EX/MEM wall yet, so a branch waits for it.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			mem_is_load <= 1'b0;
		else
			mem_is_load <= ex_mem_read;
	end

	assign branch_taken  = is_beq && (cmp_a == cmp_b);
	assign branch_target = id_pc + 32'd4 + {id_imm[`CPU_XLEN-3:0], 2'b00};

	assign load_use = ex_mem_read && ex_dst != '0 &&
		(ex_dst == id_rs || (uses_rt && ex_dst == id_rt));
	assign branch_dep = is_beq &&
		((ex_reg_write && ex_dst != '0 && (ex_dst == id_rs || ex_dst == id_rt)) ||
		(mem_is_load && mem_dst != '0 && (mem_dst == id_rs || mem_dst == id_rt)));

	assign do_hazard = load_use | branch_dep | ~fetch_grant;
	assign do_flush  = branch_taken & ~do_hazard;

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module exec_unit (
	input  wire  [`CPU_XLEN-1:0]      ex_ra_data,
	input  wire  [`CPU_XLEN-1:0]      ex_rt_data,
	input  wire  [`CPU_XLEN-1:0]      ex_imm,
	input  wire  [`CPU_RADDR_W-1:0]   ex_rs,
	input  wire  [`CPU_RADDR_W-1:0]   ex_rt,
	input  pipe_pkg::alu_op_e         ex_alu_op,
	input  wire                       ex_alu_imm,
	input  wire  [`CPU_RADDR_W-1:0]   mem_dst,
	input  wire                       mem_reg_write,
	input  wire  [`CPU_XLEN-1:0]      mem_result,
	input  wire  [`CPU_RADDR_W-1:0]   wb_dst,
	input  wire                       wb_reg_write,
	input  wire  [`CPU_XLEN-1:0]      wb_value,
	output logic [`CPU_XLEN-1:0]      ex_result,
	output logic [`CPU_XLEN-1:0]      ex_store_data
);

	logic [`CPU_XLEN-1:0] src_a;
	logic [`CPU_XLEN-1:0] src_b;

	// the younger result wins, so EX/MEM is checked before MEM/WB.
	function automatic logic [`CPU_XLEN-1:0] fwd(
		input logic [`CPU_RADDR_W-1:0] addr,
		input logic [`CPU_XLEN-1:0]    rf_data
	);
		if (mem_reg_write && mem_dst != '0 && mem_dst == addr)
			return mem_result;
		if (wb_reg_write && wb_dst != '0 && wb_dst == addr)
			return wb_value;
		return rf_data;
	endfunction

	always_comb begin
		src_a         = fwd(ex_rs, ex_ra_data);
		ex_store_data = fwd(ex_rt, ex_rt_data); // store data takes the same path.
		src_b         = ex_alu_imm ? ex_imm : ex_store_data;
		case (ex_alu_op)
			pipe_pkg::ALU_ADD: ex_result = src_a + src_b;
			pipe_pkg::ALU_SUB: ex_result = src_a - src_b;
			pipe_pkg::ALU_AND: ex_result = src_a & src_b;
			pipe_pkg::ALU_OR:  ex_result = src_a | src_b;
			pipe_pkg::ALU_SLT: ex_result = {{(`CPU_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			default:           ex_result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module mem_arbiter (
	// fetch port
	input  wire  [`CPU_XLEN-1:0] fetch_addr,
	output logic                 fetch_grant,
	output logic [`CPU_XLEN-1:0] fetch_instr,

	// data port, fed from the EX/MEM wall
	input  wire                  data_read,
	input  wire                  data_write,
	input  wire  [`CPU_XLEN-1:0] data_addr,
	input  wire  [`CPU_XLEN-1:0] data_wdata,
	output logic [`CPU_XLEN-1:0] data_rdata,

	// shared single-port bus
	output logic [`CPU_XLEN-1:0] mem_addr,
	output logic [`CPU_XLEN-1:0] mem_wdata,
	output logic                 mem_we,
	input  wire  [`CPU_XLEN-1:0] mem_rdata
);

	logic data_req;

	// fixed priority. The data side is served in the cycle it asks.
	assign data_req    = data_read | data_write;
	assign fetch_grant = ~data_req;

	assign mem_addr  = data_req ? data_addr : fetch_addr;
	assign mem_wdata = data_wdata;
	assign mem_we    = data_write;

	// a denied fetch hands back an all-zero word, which decodes as a no-op.
	assign fetch_instr = fetch_grant ? mem_rdata : '0;
	assign data_rdata  = data_read ? mem_rdata : '0;

endmodule

`default_nettype wire

/* src/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_core (
	input  wire                  clock,
	input  wire                  arst_n,
	output logic [`CPU_XLEN-1:0] mem_addr,
	output logic [`CPU_XLEN-1:0] mem_wdata,
	output logic                 mem_we,
	input  wire  [`CPU_XLEN-1:0] mem_rdata
);

	logic [`CPU_XLEN-1:0]    if_pc, if_instr, id_instr, id_pc, branch_target;
	logic [`CPU_XLEN-1:0]    id_ra_data, id_rt_data, id_imm;
	logic [`CPU_XLEN-1:0]    ex_ra_data, ex_rt_data, ex_imm, ex_result, ex_store_data;
	logic [`CPU_XLEN-1:0]    mem_result, mem_store_data, data_rdata, wb_data, wb_value;
	logic [`CPU_RADDR_W-1:0] id_rs, id_rt, id_dst, ex_rs, ex_rt, ex_dst, mem_dst, wb_dst;
	pipe_pkg::alu_op_e       id_alu_op, ex_alu_op;
	pipe_pkg::wb_sel_e       id_wb_sel, ex_wb_sel, mem_wb_sel;
	logic                    id_alu_imm, id_mem_read, id_mem_write, id_reg_write;
	logic                    ex_alu_imm, ex_mem_read, ex_mem_write, ex_reg_write;
	logic                    mem_mem_read, mem_mem_write, mem_reg_write, wb_reg_write;
	logic                    do_hazard, do_flush, branch_taken, fetch_grant;

	// program counter. A stall refetches the same word next cycle.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			if_pc <= `CPU_RESET_PC;
		else if (!do_hazard)
			if_pc <= branch_taken ? branch_target : if_pc + 32'd4;
	end

	assign wb_data = (mem_wb_sel == pipe_pkg::WB_MEM) ? data_rdata : mem_result; // load or ALU.

	pipe_walls u_walls (.*);

	decode_unit u_decode (.*);

	exec_unit u_exec (.*);

	mem_arbiter u_arbiter (
		.fetch_addr  (if_pc),
		.fetch_grant (fetch_grant),
		.fetch_instr (if_instr),
		.data_read   (mem_mem_read),
		.data_write  (mem_mem_write),
		.data_addr   (mem_result),
		.data_wdata  (mem_store_data),
		.data_rdata  (data_rdata),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_we      (mem_we),
		.mem_rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

/* test/cpu_props.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_props (
	input wire                 clock,
	input wire                 arst_n,
	input wire                 do_hazard,
	input wire                 do_flush,
	input wire [`CPU_XLEN-1:0] id_instr,
	input wire                 ex_mem_read,
	input wire                 ex_mem_write,
	input wire                 ex_reg_write,
	input wire                 mem_mem_write,
	input wire                 mem_reg_write,
	input wire                 wb_reg_write
);

	// the fetch behind a taken branch turns into a no-op.
	flush_clears_fetch: assert property (@(posedge clock) disable iff (!arst_n)
		do_flush |=> id_instr == '0)
		else $error("IF/ID kept an instruction after a flush");

	stall_bubbles_and_holds: assert property (@(posedge clock) disable iff (!arst_n)
		do_hazard |=> !ex_mem_read && !ex_mem_write && !ex_reg_write &&
			id_instr == $past(id_instr))
		else $error("a stall did not hold IF/ID or did not bubble ID/EX");

	reset_keeps_writes_low: assert property (@(posedge clock)
		!arst_n |-> !ex_mem_write && !mem_mem_write && !ex_reg_write &&
			!mem_reg_write && !wb_reg_write)
		else $error("a write control was high during reset");

endmodule

bind pipe_walls cpu_props u_props (
	.clock         (clock),
	.arst_n        (arst_n),
	.do_hazard     (do_hazard),
	.do_flush      (do_flush),
	.id_instr      (id_instr),
	.ex_mem_read   (ex_mem_read),
	.ex_mem_write  (ex_mem_write),
	.ex_reg_write  (ex_reg_write),
	.mem_mem_write (mem_mem_write),
	.mem_reg_write (mem_reg_write),
	.wb_reg_write  (wb_reg_write)
);

`default_nettype wire

/* test/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_checker #(
	parameter int MEM_WORDS = 512
) (
	input  wire                 clock,
	input  wire                 arst_n,
	input  wire                 image_valid,
	input  wire [`CPU_XLEN-1:0] image [0:MEM_WORDS-1],
	input  wire [`CPU_XLEN-1:0] mem_addr,
	input  wire [`CPU_XLEN-1:0] mem_wdata,
	input  wire                 mem_we,
	output bit                  done,
	output int                  mismatch_errors,
	output int                  missing_errors,
	output int                  extra_errors,
	output int                  reset_errors
);

	localparam int STEP_LIMIT    = 10000;
	localparam int DRAIN_FETCHES = 8; // fetches of the final beq before the pipeline is empty.

	logic [`CPU_XLEN-1:0] exp_addr [$];
	logic [`CPU_XLEN-1:0] exp_data [$];
	logic [`CPU_XLEN-1:0] end_pc;
	logic [`CPU_XLEN-1:0] want_addr;
	logic [`CPU_XLEN-1:0] want_data;
	bit                   model_ready;
	int                   end_seen;

	// ******************************************************************
	// instruction-set model, one instruction per step
	// ******************************************************************
	task automatic run_model();
		logic [`CPU_XLEN-1:0] data [0:MEM_WORDS-1];
		logic [`CPU_XLEN-1:0] regs [0:31];
		logic [`CPU_XLEN-1:0] pc, next_pc, instr, a, b, imm, addr;
		logic [5:0]           op, fn;
		int                   steps;
		bit                   stop;
		for (int w = 0; w < MEM_WORDS; w++)
			data[w] = image[w];
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		pc    = `CPU_RESET_PC;
		steps = 0;
		stop  = 1'b0;
		while (!stop && steps < STEP_LIMIT) begin
			instr   = data[pc[10:2]];
			op      = instr[31:26];
			fn      = instr[5:0];
			a       = regs[instr[25:21]];
			b       = regs[instr[20:16]];
			imm     = {{16{instr[15]}}, instr[15:0]};
			next_pc = pc + 32'd4;
			case (op)
				isa_pkg::OP_RTYPE: begin
					case (fn)
						isa_pkg::FN_ADD: regs[instr[15:11]] = a + b;
						isa_pkg::FN_SUB: regs[instr[15:11]] = a - b;
						isa_pkg::FN_AND: regs[instr[15:11]] = a & b;
						isa_pkg::FN_OR:  regs[instr[15:11]] = a | b;
						isa_pkg::FN_SLT: regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				isa_pkg::OP_ADDI: regs[instr[20:16]] = a + imm;
				isa_pkg::OP_LW: begin
					addr = a + imm;
					regs[instr[20:16]] = data[addr[10:2]];
				end
				isa_pkg::OP_SW: begin
					addr = a + imm;
					data[addr[10:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				isa_pkg::OP_BEQ: begin
					if (a == b)
						next_pc = pc + 32'd4 + (imm << 2);
				end
				default: ;
			endcase
			regs[0] = '0; // register zero ignores every write.
			stop    = (next_pc == pc);
			if (!stop)
				pc = next_pc;
			steps++;
		end
		end_pc = pc;
	endtask

	// ******************************************************************
	// store stream comparison
	// ******************************************************************
	always @(posedge clock) begin
		if (!model_ready && image_valid) begin
			run_model();
			model_ready = 1'b1;
		end
		if (!arst_n) begin
			if (mem_we !== 1'b0) begin
				reset_errors++;
				$display("mem_we was not low while reset was asserted");
			end
		end else if (!done) begin
			if (mem_we) begin
				if (exp_addr.size() == 0) begin
					extra_errors++;
					$display("extra store of %h to %h after the last predicted store",
						mem_wdata, mem_addr);
				end else begin
					want_addr = exp_addr.pop_front();
					want_data = exp_data.pop_front();
					if (mem_addr !== want_addr) begin
						mismatch_errors++;
						$display("Mismatch mem_addr: got %h, expected %h", mem_addr, want_addr);
					end
					if (mem_wdata !== want_data) begin
						mismatch_errors++;
						$display("Mismatch mem_wdata: got %h, expected %h", mem_wdata, want_data);
					end
				end
			end else if (mem_addr == end_pc) begin
				end_seen++;
			end
			if (end_seen >= DRAIN_FETCHES) begin
				missing_errors = exp_addr.size();
				if (missing_errors != 0)
					$display("%0d predicted stores never reached the bus", missing_errors);
				done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb;

	localparam int PROG_LEN     = 200;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT  = 4 * PROG_LEN + RESET_CYCLES;
	localparam int MEM_WORDS    = 512; // addressed by bits 10:2.
	localparam int DATA_BASE    = 32'h400;

	logic                 clock;
	logic                 arst_n;
	logic [`CPU_XLEN-1:0] mem_addr;
	logic [`CPU_XLEN-1:0] mem_wdata;
	logic [`CPU_XLEN-1:0] mem_rdata;
	logic                 mem_we;
	logic [`CPU_XLEN-1:0] image [0:MEM_WORDS-1];
	logic [`CPU_XLEN-1:0] mem [0:MEM_WORDS-1];
	logic [31:0]          lcg_state;
	logic                 image_valid;
	bit                   done;
	int                   mismatch_errors, missing_errors, extra_errors, reset_errors;
	int                   cycles;
	int                   timed_out;

	cpu_core UUT (.*);

	cpu_checker #(.MEM_WORDS(MEM_WORDS)) u_checker (
		.clock           (clock),
		.arst_n          (arst_n),
		.image_valid     (image_valid),
		.image           (image),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_we          (mem_we),
		.done            (done),
		.mismatch_errors (mismatch_errors),
		.missing_errors  (missing_errors),
		.extra_errors    (extra_errors),
		.reset_errors    (reset_errors)
	);

	always #20 clock = ~clock;

	always @(posedge clock)
		cycles <= cycles + 1;

	// memory model. The image is loaded during reset.
	assign mem_rdata = mem[mem_addr[10:2]];

	always @(posedge clock) begin
		if (!arst_n) begin
			for (int w = 0; w < MEM_WORDS; w++)
				mem[w] <= image[w];
		end else if (mem_we) begin
			mem[mem_addr[10:2]] <= mem_wdata;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic pick(input int n, output int value);
		lcg_state = lcg_next(lcg_state);
		value     = int'(lcg_state[31:16]) % n;
	endtask

	// r1 holds the data base, so only r0 and r2 to r7 are written.
	task automatic pick_dst(output int r);
		int d;
		pick(7, d);
		r = (d == 0) ? 0 : d + 1;
	endtask

	function automatic logic [31:0] r_type(input int rs, rt, rd, input logic [5:0] funct);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input int rs, rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [5:0] funct_of(input int f);
		case (f)
			0:       return isa_pkg::FN_ADD;
			1:       return isa_pkg::FN_SUB;
			2:       return isa_pkg::FN_AND;
			3:       return isa_pkg::FN_OR;
			4:       return isa_pkg::FN_SLT;
			default: return 6'h3f; // not an ALU funct, so a no-op.
		endcase
	endfunction

	// ******************************************************************
	// random program with a forward-only branch mix
	// ******************************************************************
	task automatic build_program();
		int kind, rs, rt, rd, k, off, f;
		for (int w = 0; w < MEM_WORDS; w++)
			image[w] = (w * 32'h9e3779b1) ^ 32'h0f0f_5a5a;
		image[0] = i_type(isa_pkg::OP_ADDI, 0, 1, 16'(DATA_BASE));
		for (int r = 2; r < 8; r++) begin
			pick(65536, k);
			image[r-1] = i_type(isa_pkg::OP_ADDI, 0, r, 16'(k));
		end
		for (int w = 7; w < PROG_LEN - 1; w++) begin
			pick(16, kind);
			if (kind < 5) begin
				pick(6, f);
				pick(8, rs);
				pick(8, rt);
				pick_dst(rd);
				image[w] = r_type(rs, rt, rd, funct_of(f));
			end else if (kind < 7) begin
				pick(8, rs);
				pick_dst(rt);
				pick(65536, k);
				image[w] = i_type(isa_pkg::OP_ADDI, rs, rt, 16'(k));
			end else if (kind < 9) begin
				pick_dst(rt);
				pick(64, k);
				image[w] = i_type(isa_pkg::OP_LW, 1, rt, 16'(4 * k));
			end else if (kind < 12) begin
				pick(8, rt);
				pick(64, k);
				image[w] = i_type(isa_pkg::OP_SW, 1, rt, 16'(4 * k));
			end else if (kind < 14) begin
				pick(8, rs);
				pick(2, k);
				if (k == 1)
					rt = rs; // equal registers give a taken branch.
				else
					pick(8, rt);
				pick(6, off);
				if (off > PROG_LEN - 2 - w)
					off = PROG_LEN - 2 - w;
				image[w] = i_type(isa_pkg::OP_BEQ, rs, rt, 16'(off));
			end else begin
				pick(65536, k);
				image[w] = {6'h3f, 10'h2a5, 16'(k)};
			end
		end
		image[PROG_LEN-1] = i_type(isa_pkg::OP_BEQ, 0, 0, 16'hffff);
	endtask

	initial begin
		int total;
		clock       = 1'b0;
		arst_n      = 1'b0;
		image_valid = 1'b0;
		timed_out   = 0;
		lcg_state   = 32'hc053;
		build_program();
		image_valid = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 arst_n = 1'b1;
		while (!done && cycles < CYCLE_LIMIT)
			@(posedge clock);
		if (!done) begin
			timed_out = 1;
			$display("timeout after %0d cycles before the program reached its final loop",
				CYCLE_LIMIT);
		end
		total = mismatch_errors + missing_errors + extra_errors + reset_errors + timed_out;
		$display("errors: mismatch %0d, missing %0d, extra %0d, reset %0d, timeout %0d",
			mismatch_errors, missing_errors, extra_errors, reset_errors, timed_out);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/pipe_walls.sv
src/decode_unit.sv
src/exec_unit.sv
src/mem_arbiter.sv
src/cpu_core.sv
test/cpu_props.sv
test/cpu_checker.sv
test/cpu_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module cpu_tb -f filelist.f -Mdir obj_dir -o cpu_sim

run: compile
	./obj_dir/cpu_sim > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
